//--- axi_apb_subsys.f
+incdir+tb
source/bridge_pkg.sv
source/apb_req_if.sv
source/axi_lite_front.sv
source/apb_master.sv
source/apb_scratch_regs.sv
source/axi_apb_subsys.sv
tb/tb_axi_apb_subsys.sv

//--- source/apb_master.sv
`timescale 1ns/1ps

module apb_master #(
    parameter int data_width     = 32,
    parameter int apb_addr_width = 20
) (
    input  logic                                S_AXI_ACLK,
    input  logic                                S_AXI_ARESETN,
    apb_req_if.master                           req,
    output logic [bridge_pkg::apb_dev_count-1:0] psel,
    output logic                                penable,
    output logic [apb_addr_width-1:0]           paddr,
    output logic                                pwrite,
    output logic [data_width-1:0]               pwdata,
    input  logic [data_width-1:0]               prdata [bridge_pkg::apb_dev_count],
    input  logic [bridge_pkg::apb_dev_count-1:0] pready,
    input  logic [bridge_pkg::apb_dev_count-1:0] pslverr
);

    localparam int sel_w = $clog2(bridge_pkg::apb_dev_count);

    bridge_pkg::apb_state_e state;

    logic [2:0]                           region;
    logic [sel_w-1:0]                     dev_num;
    logic [sel_w-1:0]                     dev_q;   // Device of the running transfer
    logic [bridge_pkg::apb_dev_count-1:0] dev_onehot;

    assign region  = req.addr[bridge_pkg::dev_idx_lsb +: 3];
    assign dev_num = bridge_pkg::dev_map[region];

    always_comb begin
        dev_onehot          = '0;
        dev_onehot[dev_num] = 1'b1;
    end

    // Completion from the addressed device only
    assign req.done   = (state == bridge_pkg::ACCESS) && pready[dev_q];
    assign req.slverr = pslverr[dev_q];
    assign req.rdata  = prdata[dev_q];

    always_ff @(posedge S_AXI_ACLK) begin
        if ((state == bridge_pkg::IDLE) && req.req) begin
            paddr  <= req.addr;
            pwdata <= req.wdata;
        end
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            state   <= bridge_pkg::IDLE;
            psel    <= '0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
            dev_q   <= '0;
        end else begin
            case (state)
                bridge_pkg::IDLE: begin
                    if (req.req) begin
                        psel   <= dev_onehot;
                        pwrite <= req.write;
                        dev_q  <= dev_num;
                        state  <= bridge_pkg::SETUP;
                    end
                end
                bridge_pkg::SETUP: begin
                    penable <= 1'b1;
                    state   <= bridge_pkg::ACCESS;
                end
                bridge_pkg::ACCESS: begin
                    if (pready[dev_q]) begin  // Wait states stretch ACCESS
                        psel    <= '0;
                        penable <= 1'b0;
                        state   <= bridge_pkg::IDLE;
                    end
                end
                default: state <= bridge_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- source/apb_req_if.sv
`timescale 1ns/1ps

interface apb_req_if #(
    parameter int data_width     = 32,
    parameter int apb_addr_width = 20
);

    logic                      req;
    logic                      write;
    logic [apb_addr_width-1:0] addr;
    logic [data_width-1:0]     wdata;
    logic                      done;    // One-cycle pulse at end of ACCESS
    logic [data_width-1:0]     rdata;
    logic                      slverr;

    modport front (
        output req, write, addr, wdata,
        input  done, rdata, slverr
    );

    modport master (
        input  req, write, addr, wdata,
        output done, rdata, slverr
    );

endinterface

//--- source/apb_scratch_regs.sv
`timescale 1ns/1ps

module apb_scratch_regs #(
    parameter int data_width     = 32,
    parameter int apb_addr_width = 20,
    parameter int dev_id         = 0,
    parameter int wait_states    = 0
) (
    input  logic                      S_AXI_ACLK,
    input  logic                      S_AXI_ARESETN,
    input  logic                      psel,
    input  logic                      penable,
    input  logic [apb_addr_width-1:0] paddr,
    input  logic                      pwrite,
    input  logic [data_width-1:0]     pwdata,
    output logic [data_width-1:0]     prdata,
    output logic                      pready,
    output logic                      pslverr
);

    localparam int cnt_w = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

    logic [data_width-1:0] regs [3];
    logic [cnt_w-1:0]      wait_cnt;
    logic [bridge_pkg::dev_idx_lsb-3:0] word_off;
    logic                  id_hit;
    logic                  bad_off;
    logic                  err;
    logic                  access;

    assign word_off = paddr[bridge_pkg::dev_idx_lsb-1:2];
    assign id_hit   = (word_off == 3);
    assign bad_off  = (word_off > 3);
    assign err      = bad_off || (pwrite && id_hit);  // Identity is read-only

    assign access  = psel && penable;
    assign pready  = access && (wait_cnt == cnt_w'(wait_states));
    assign pslverr = pready && err;

    always_comb begin
        prdata = '0;
        if (psel && !bad_off) begin
            if (id_hit) prdata = data_width'(dev_id);
            else        prdata = regs[word_off[1:0]];
        end
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            wait_cnt <= '0;
            for (int i = 0; i < 3; i++) regs[i] <= '0;
        end else begin
            if (access && !pready) wait_cnt <= wait_cnt + 1'b1;
            else                   wait_cnt <= '0;
            if (pready && pwrite && !err) regs[word_off[1:0]] <= pwdata;
        end
    end

endmodule

//--- source/axi_apb_subsys.sv
`timescale 1ns/1ps

module axi_apb_subsys #(
    parameter int data_width     = 32,
    parameter int axi_addr_width = 20,
    parameter int apb_addr_width = 20
) (
    input  logic                      S_AXI_ACLK,
    input  logic                      S_AXI_ARESETN,
    input  logic [axi_addr_width-1:0] s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  logic [data_width-1:0]     s_axi_wdata,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    output logic [1:0]                s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,
    input  logic [axi_addr_width-1:0] s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output logic [data_width-1:0]     s_axi_rdata,
    output logic [1:0]                s_axi_rresp,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready
);

    localparam int n_dev = bridge_pkg::apb_dev_count;

    logic [n_dev-1:0]          psel;
    logic                      penable;
    logic [apb_addr_width-1:0] paddr;
    logic                      pwrite;
    logic [data_width-1:0]     pwdata;
    logic [data_width-1:0]     prdata [n_dev];
    logic [n_dev-1:0]          pready;
    logic [n_dev-1:0]          pslverr;

    apb_req_if #(
        .data_width     (data_width),
        .apb_addr_width (apb_addr_width)
    ) req_if ();

    axi_lite_front #(
        .data_width     (data_width),
        .axi_addr_width (axi_addr_width),
        .apb_addr_width (apb_addr_width)
    ) front_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .req           (req_if.front)
    );

    apb_master #(
        .data_width     (data_width),
        .apb_addr_width (apb_addr_width)
    ) master_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .req           (req_if.master),
        .psel          (psel),
        .penable       (penable),
        .paddr         (paddr),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr)
    );

    // Device g sits on psel[g], wait states cycle 0..2
    for (genvar g = 0; g < n_dev; g++) begin : g_dev
        apb_scratch_regs #(
            .data_width     (data_width),
            .apb_addr_width (apb_addr_width),
            .dev_id         (g),
            .wait_states    (g % 3)
        ) regs_i (
            .S_AXI_ACLK    (S_AXI_ACLK),
            .S_AXI_ARESETN (S_AXI_ARESETN),
            .psel          (psel[g]),
            .penable       (penable),
            .paddr         (paddr),
            .pwrite        (pwrite),
            .pwdata        (pwdata),
            .prdata        (prdata[g]),
            .pready        (pready[g]),
            .pslverr       (pslverr[g])
        );
    end

endmodule

//--- source/axi_lite_front.sv
`timescale 1ns/1ps

module axi_lite_front #(
    parameter int data_width     = 32,
    parameter int axi_addr_width = 20,
    parameter int apb_addr_width = 20
) (
    input  logic                      S_AXI_ACLK,
    input  logic                      S_AXI_ARESETN,
    input  logic [axi_addr_width-1:0] s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  logic [data_width-1:0]     s_axi_wdata,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    output logic [1:0]                s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,
    input  logic [axi_addr_width-1:0] s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output logic [data_width-1:0]     s_axi_rdata,
    output logic [1:0]                s_axi_rresp,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready,
    apb_req_if.front                  req
);

    bridge_pkg::wr_state_e wr_state;
    bridge_pkg::rd_state_e rd_state;
    bridge_pkg::axi_resp_e apb_resp;

    logic [axi_addr_width-1:0] awaddr_q;
    logic [axi_addr_width-1:0] araddr_q;
    logic [data_width-1:0]     wdata_q;
    logic [axi_addr_width-1:0] wr_addr_now;
    logic [axi_addr_width-1:0] rd_addr_now;
    logic [data_width-1:0]     wr_data_now;

    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic wr_owns;
    logic rd_owns;
    logic wr_go;
    logic rd_go;
    logic path_free;
    logic issue;

    assign aw_hs = s_axi_awvalid && s_axi_awready;
    assign w_hs  = s_axi_wvalid && s_axi_wready;
    assign ar_hs = s_axi_arvalid && s_axi_arready;

    // Bypass capture regs so a request can go out on the handshake edge
    assign wr_addr_now = aw_hs ? s_axi_awaddr : awaddr_q;
    assign wr_data_now = w_hs ? s_axi_wdata : wdata_q;
    assign rd_addr_now = ar_hs ? s_axi_araddr : araddr_q;

    assign wr_owns = req.req && req.write;
    assign rd_owns = req.req && !req.write;

    assign wr_go = ((wr_state == bridge_pkg::WR_IDLE) && aw_hs && w_hs)
                || ((wr_state == bridge_pkg::WR_ADDR) && w_hs)
                || ((wr_state == bridge_pkg::WR_DATA) && aw_hs)
                || ((wr_state == bridge_pkg::WR_WAIT) && !wr_owns);
    assign rd_go = ((rd_state == bridge_pkg::RD_IDLE) && ar_hs)
                || ((rd_state == bridge_pkg::RD_WAIT) && !rd_owns);

    assign path_free = !req.req || req.done;
    assign issue     = path_free && (rd_go || wr_go);

    assign apb_resp = req.slverr ? bridge_pkg::SLVERR : bridge_pkg::OKAY;

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) awaddr_q <= s_axi_awaddr;
        if (w_hs)  wdata_q  <= s_axi_wdata;
        if (ar_hs) araddr_q <= s_axi_araddr;
        if (issue) begin
            req.addr  <= rd_go ? rd_addr_now[apb_addr_width-1:0]
                               : wr_addr_now[apb_addr_width-1:0];
            req.wdata <= wr_data_now;
        end
        if ((rd_state == bridge_pkg::RD_WAIT) && rd_owns && req.done)
            s_axi_rdata <= req.rdata;
    end

    // Read wins a tie
    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            req.req   <= 1'b0;
            req.write <= 1'b0;
        end else if (issue) begin
            req.req   <= 1'b1;
            req.write <= !rd_go;
        end else if (req.done) begin
            req.req <= 1'b0;
        end
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            wr_state      <= bridge_pkg::WR_IDLE;
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_bresp   <= bridge_pkg::OKAY;
        end else begin
            case (wr_state)
                bridge_pkg::WR_IDLE: begin
                    s_axi_awready <= !aw_hs;
                    s_axi_wready  <= !w_hs;
                    if (aw_hs && w_hs) wr_state <= bridge_pkg::WR_WAIT;
                    else if (aw_hs)    wr_state <= bridge_pkg::WR_ADDR;
                    else if (w_hs)     wr_state <= bridge_pkg::WR_DATA;
                end
                bridge_pkg::WR_ADDR: begin
                    if (w_hs) begin
                        s_axi_wready <= 1'b0;
                        wr_state     <= bridge_pkg::WR_WAIT;
                    end
                end
                bridge_pkg::WR_DATA: begin
                    if (aw_hs) begin
                        s_axi_awready <= 1'b0;
                        wr_state      <= bridge_pkg::WR_WAIT;
                    end
                end
                bridge_pkg::WR_WAIT: begin
                    if (wr_owns && req.done) begin
                        s_axi_bvalid <= 1'b1;
                        s_axi_bresp  <= apb_resp;
                        wr_state     <= bridge_pkg::WR_RESP;
                    end
                end
                bridge_pkg::WR_RESP: begin
                    if (s_axi_bready) begin  // Reopen both channels
                        s_axi_bvalid  <= 1'b0;
                        s_axi_awready <= 1'b1;
                        s_axi_wready  <= 1'b1;
                        wr_state      <= bridge_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= bridge_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            rd_state      <= bridge_pkg::RD_IDLE;
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            s_axi_rresp   <= bridge_pkg::OKAY;
        end else begin
            case (rd_state)
                bridge_pkg::RD_IDLE: begin
                    s_axi_arready <= !ar_hs;
                    if (ar_hs) rd_state <= bridge_pkg::RD_WAIT;
                end
                bridge_pkg::RD_WAIT: begin
                    if (rd_owns && req.done) begin
                        s_axi_rvalid <= 1'b1;
                        s_axi_rresp  <= apb_resp;
                        rd_state     <= bridge_pkg::RD_RESP;
                    end
                end
                bridge_pkg::RD_RESP: begin
                    if (s_axi_rready) begin
                        s_axi_rvalid  <= 1'b0;
                        s_axi_arready <= 1'b1;
                        rd_state      <= bridge_pkg::RD_IDLE;
                    end
                end
                default: rd_state <= bridge_pkg::RD_IDLE;
            endcase
        end
    end

endmodule

//--- source/bridge_pkg.sv
package bridge_pkg;

    // Eight APB peripherals behind the bridge
    localparam int apb_dev_count = 8;

    // Region index sits in address bits 15:13, 8 KB per region
    localparam int dev_idx_lsb = 13;

    // Region to device number
    localparam logic [2:0] dev_map [apb_dev_count] = '{
        3'd0, 3'd3, 3'd4, 3'd5, 3'd1, 3'd2, 3'd6, 3'd7
    };

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic [2:0] {
        WR_IDLE = 3'd0,  // Waiting for AW and W
        WR_ADDR = 3'd1,  // Have address, need data
        WR_DATA = 3'd2,  // Have data, need address
        WR_WAIT = 3'd3,  // Queued or running on APB
        WR_RESP = 3'd4
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE = 2'd0,
        RD_WAIT = 2'd1,
        RD_RESP = 2'd2
    } rd_state_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        SETUP  = 2'd1,
        ACCESS = 2'd2
    } apb_state_e;

endpackage

//--- tb/axi_lite_tasks.svh
function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
endfunction

function automatic logic [19:0] word_addr(input int region, input int off);
    return 20'((region << bridge_pkg::dev_idx_lsb) | (off << 2));
endfunction

// Offset 3 is read-only, 4 and up is unmapped
function automatic logic [1:0] expect_resp(input int off, input bit is_write);
    if (off > 3 || (off == 3 && is_write)) return bridge_pkg::SLVERR;
    return bridge_pkg::OKAY;
endfunction

function automatic logic [31:0] expect_rdata(input int region, input int off);
    if (off < 3) return model_mem[bridge_pkg::dev_map[region]][off];
    if (off == 3) return 32'(bridge_pkg::dev_map[region]);
    return '0;
endfunction

function automatic bit ready_of(input int ch);
    case (ch)
        0: return s_axi_awready;
        1: return s_axi_wready;
        2: return s_axi_arready;
        3: return s_axi_bvalid;
        default: return s_axi_rvalid;
    endcase
endfunction

// Polls on falling edges where DUT outputs are settled
task automatic wait_for(input int ch, input string what);
    int t = 0;
    while (!ready_of(ch) && t < wait_limit) begin
        @(negedge S_AXI_ACLK);
        t++;
    end
    if (!ready_of(ch)) begin
        timeouts++;
        $display("Timed out at %0t ns waiting for %s", $time, what);
    end
endtask

task automatic send_aw(input logic [19:0] addr);
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    wait_for(0, "AWREADY");
    @(negedge S_AXI_ACLK);
    s_axi_awvalid = 1'b0;
endtask

task automatic send_w(input logic [31:0] data);
    s_axi_wdata  = data;
    s_axi_wvalid = 1'b1;
    wait_for(1, "WREADY");
    @(negedge S_AXI_ACLK);
    s_axi_wvalid = 1'b0;
endtask

task automatic send_ar(input logic [19:0] addr);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    wait_for(2, "ARREADY");
    @(negedge S_AXI_ACLK);
    s_axi_arvalid = 1'b0;
endtask

// Gaps delay AW or W, hold delays BREADY after BVALID
task automatic write_word(input int region, input int off, input logic [31:0] data,
                          input int aw_gap, input int w_gap, input int hold);
    fork
        begin
            repeat (aw_gap) @(negedge S_AXI_ACLK);
            send_aw(word_addr(region, off));
        end
        begin
            repeat (w_gap) @(negedge S_AXI_ACLK);
            send_w(data);
        end
    join
    exp_bresp = expect_resp(off, 1'b1);
    wait_for(3, "BVALID");
    repeat (hold) @(negedge S_AXI_ACLK);
    s_axi_bready = 1'b1;
    @(negedge S_AXI_ACLK);
    s_axi_bready = 1'b0;
    if (off < 3) model_mem[bridge_pkg::dev_map[region]][off] = data;
endtask

task automatic read_word(input int region, input int off, input int hold);
    exp_rdata = expect_rdata(region, off);
    exp_rresp = expect_resp(off, 1'b0);
    send_ar(word_addr(region, off));
    wait_for(4, "RVALID");
    repeat (hold) @(negedge S_AXI_ACLK);
    s_axi_rready = 1'b1;
    @(negedge S_AXI_ACLK);
    s_axi_rready = 1'b0;
endtask

//--- tb/tb_axi_apb_subsys.sv
`timescale 1ns/1ps

module tb_axi_apb_subsys;

    localparam int data_width = 32;
    localparam int addr_width = 20;
    localparam int wait_limit = 200;  // Cycles per handshake wait

    logic                  S_AXI_ACLK = 1'b1;
    logic                  S_AXI_ARESETN;
    logic [addr_width-1:0] s_axi_awaddr;
    logic                  s_axi_awvalid;
    logic                  s_axi_awready;
    logic [data_width-1:0] s_axi_wdata;
    logic                  s_axi_wvalid;
    logic                  s_axi_wready;
    logic [1:0]            s_axi_bresp;
    logic                  s_axi_bvalid;
    logic                  s_axi_bready;
    logic [addr_width-1:0] s_axi_araddr;
    logic                  s_axi_arvalid;
    logic                  s_axi_arready;
    logic [data_width-1:0] s_axi_rdata;
    logic [1:0]            s_axi_rresp;
    logic                  s_axi_rvalid;
    logic                  s_axi_rready;

    int                    mismatches = 0;
    int                    timeouts   = 0;
    logic [31:0]           rng_state  = 32'd33;
    logic [data_width-1:0] model_mem [bridge_pkg::apb_dev_count][3];  // Per device number
    logic [data_width-1:0] exp_rdata;
    logic [1:0]            exp_rresp;
    logic [1:0]            exp_bresp;

    always #4 S_AXI_ACLK = ~S_AXI_ACLK;

    axi_apb_subsys #(
        .data_width     (data_width),
        .axi_addr_width (addr_width),
        .apb_addr_width (addr_width)
    ) dut_i (.*);

    function automatic void report_mismatch(input string msg);
        mismatches++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endfunction

    `include "axi_lite_tasks.svh"

    assert property (@(posedge S_AXI_ACLK) !S_AXI_ARESETN |-> !s_axi_awready && !s_axi_wready
        && !s_axi_arready && !s_axi_bvalid && !s_axi_rvalid && dut_i.psel == '0
        && !dut_i.penable)
        else report_mismatch("handshake or APB select outputs not low in reset");
    assert property (@(posedge S_AXI_ACLK) $rose(S_AXI_ARESETN)
        |=> s_axi_awready && s_axi_wready && s_axi_arready)
        else report_mismatch("address and data READY not high after reset");
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid && s_axi_bready |-> s_axi_bresp == exp_bresp)
        else report_mismatch("wrong BRESP");
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && s_axi_rready |-> s_axi_rdata == exp_rdata && s_axi_rresp == exp_rresp)
        else report_mismatch("wrong RDATA or RRESP");
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
        else report_mismatch("B channel changed under back-pressure");
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
        && $stable(s_axi_rresp))
        else report_mismatch("R channel changed under back-pressure");

    initial begin
        int hold;
        S_AXI_ARESETN = 1'b1;
        {s_axi_awaddr, s_axi_awvalid, s_axi_wdata, s_axi_wvalid, s_axi_bready} = '0;
        {s_axi_araddr, s_axi_arvalid, s_axi_rready} = '0;
        for (int d = 0; d < bridge_pkg::apb_dev_count; d++)
            for (int o = 0; o < 3; o++) model_mem[d][o] = '0;
        @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b0;
        repeat (4) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        repeat (2) @(negedge S_AXI_ACLK);

        for (int r = 0; r < 8; r++)
            for (int o = 0; o < 3; o++) write_word(r, o, xorshift(), 0, 0, 0);
        for (int r = 0; r < 8; r++)
            for (int o = 0; o < 3; o++) read_word(r, o, 0);

        // Identity register, also after a rejected write
        for (int r = 0; r < 8; r++) begin
            read_word(r, 3, 0);
            write_word(r, 3, xorshift(), 0, 0, 0);
            read_word(r, 3, 0);
        end

        for (int r = 0; r < 8; r++) begin
            write_word(r, (r % 2) ? 2047 : 4 + r, xorshift(), 0, 0, 0);
            read_word(r, (r % 2) ? 4 + r : 2047, 0);
            for (int o = 0; o < 3; o++) read_word(r, o, 0);
        end

        // Write and read launched together, both responses stalled
        for (int k = 0; k < 4; k++) begin
            hold = int'(xorshift() % 8) + 1;
            fork
                write_word(k, 1, xorshift(), 0, 0, hold);
                read_word(7 - k, 2, hold % 3 + 1);
            join
            read_word(k, 1, 0);
        end

        write_word(2, 0, xorshift(), 0, 3, 0);  // AW first
        write_word(5, 2, xorshift(), 4, 0, 0);  // W first
        read_word(2, 0, 0);
        read_word(5, 2, 0);

        repeat (2) @(negedge S_AXI_ACLK);
        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
